// File: rvMulti.f
src/rvPkg.sv
src/stateSequencer.sv
src/microController.sv
src/datapath.sv
src/wbMaster.sv
src/rvMulti.sv
tb/clockGen.sv
tb/tbRvMulti.sv

// File: run.sh
#!/bin/sh
# build and run the testbench, then decide pass or fail from the log
verilator --binary --timing --assert --timescale 1ns/100ps -f rvMulti.f \
    --top-module tbRvMulti -o simRvMulti > build.log 2>&1 \
    && ./obj_dir/simRvMulti > sim.log 2>&1 \
    || { cat build.log; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Regression failed" sim.log && exit 1 || exit 0

// File: tb/tbRvMulti.sv
`timescale 1ns/100ps

module tbRvMulti;
    import rvPkg::*;

    // executed instructions over all tests rounded up
    localparam int maxInstr    = 80;
    // a load with three wait states on both bus phases
    localparam int pathCycles  = 16;
    localparam int testCount   = 5;
    localparam int limitCycles = (maxInstr * pathCycles + testCount * 12 + 50 + 16) * 2;

    logic        clk;
    logic        genReset;
    logic        pulseReset;
    logic        dutReset;
    logic        wbCyc;
    logic        wbStb;
    logic        wbWe;
    logic [31:0] wbAdr;
    logic [31:0] wbDatO;
    logic [3:0]  wbSel;
    logic [31:0] wbDatI;
    logic        wbAck;
    logic        halted;

    logic [31:0] mem [1024];
    logic [31:0] loadImg [1024];
    logic [31:0] storeAdr [$];
    logic [31:0] storeDat [$];
    logic [31:0] expAdr [$];
    logic [31:0] expDat [$];
    logic [31:0] memLfsr;
    logic [31:0] testLfsr;
    logic [1:0]  waitLeft;
    int          emitIdx;
    int          checks;
    int          errors;
    int          busChecks;
    int          busErrors;

    logic        prevStb;
    logic        prevAck;
    logic        prevWe;
    logic [31:0] prevAdr;
    logic [31:0] prevDat;
    logic        expectFirst;

    assign dutReset = genReset || pulseReset;

    clockGen clockGenInst (
        .clk   (clk),
        .reset (genReset)
    );

    rvMulti rvMulti_inst (
        .clk    (clk),
        .reset  (dutReset),
        .wbCyc  (wbCyc),
        .wbStb  (wbStb),
        .wbWe   (wbWe),
        .wbAdr  (wbAdr),
        .wbDatO (wbDatO),
        .wbSel  (wbSel),
        .wbDatI (wbDatI),
        .wbAck  (wbAck),
        .halted (halted)
    );

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // instruction encoders
    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opArith};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2);
        return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], opStore};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
    endfunction

    function automatic logic [31:0] sext(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    // wishbone slave with 0 to 3 wait states
    initial begin
        wbAck   <= 1'b0;
        wbDatI  <= '0;
        memLfsr  = 32'h9dcb4610;
        waitLeft = 2'd0;
        forever begin
            @(posedge clk);
            if (dutReset) begin
                wbAck <= 1'b0;
                for (int i = 0; i < 1024; i++) begin
                    mem[i] = loadImg[i];
                end
                storeAdr.delete();
                storeDat.delete();
            end else if (wbAck) begin
                wbAck <= 1'b0;
                memLfsr     = lfsrNext(memLfsr);
                waitLeft[1] = memLfsr[0];
                memLfsr     = lfsrNext(memLfsr);
                waitLeft[0] = memLfsr[0];
            end else if (wbCyc && wbStb) begin
                if (waitLeft == 2'd0) begin
                    wbAck <= 1'b1;
                    if (wbWe) begin
                        mem[wbAdr[11:2]] = wbDatO;
                        storeAdr.push_back(wbAdr);
                        storeDat.push_back(wbDatO);
                    end else begin
                        wbDatI <= mem[wbAdr[11:2]];
                    end
                end else begin
                    waitLeft = waitLeft - 2'd1;
                end
            end
        end
    end

    // bus protocol monitor
    always @(posedge clk) begin
        if (dutReset) begin
            expectFirst <= 1'b1;
        end else begin
            busChecks <= busChecks + 1;
            assert (!wbStb || wbCyc) else begin
                busErrors++;
                $display("Bus protocol: stb high without cyc at %0t ns", $time);
            end
            assert (wbSel == 4'hf) else begin
                busErrors++;
                $display("Error at %0t ns: wbSel got %h expected f", $time, wbSel);
            end
            // an open request stays up until the slave acks
            if (prevStb && !prevAck) begin
                assert (wbCyc && wbStb) else begin
                    busErrors++;
                    $display("Bus protocol: request dropped before ack at %0t ns", $time);
                end
                assert (wbAdr == prevAdr && wbWe == prevWe && wbDatO == prevDat) else begin
                    busErrors++;
                    $display("Bus protocol: request changed before ack at %0t ns", $time);
                end
            end
            if (expectFirst && wbCyc && wbStb) begin
                expectFirst <= 1'b0;
                assert (wbAdr == 32'd0) else begin
                    busErrors++;
                    $display("Error at %0t ns: first wbAdr got %h expected 00000000",
                             $time, wbAdr);
                end
            end
        end
        prevStb <= wbStb;
        prevAck <= wbAck;
        prevWe  <= wbWe;
        prevAdr <= wbAdr;
        prevDat <= wbDatO;
    end

    initial begin
        busChecks = 0;
        busErrors = 0;
    end

    task automatic drawBits(input int n, output logic [31:0] w);
        w = '0;
        for (int i = 0; i < n; i++) begin
            testLfsr = lfsrNext(testLfsr);
            w = {w[30:0], testLfsr[0]};
        end
    endtask

    task automatic clearImage();
        for (int i = 0; i < 1024; i++) begin
            loadImg[i] = {6'h2a, i[9:0], 6'h15, i[9:0]};
        end
        emitIdx = 0;
        expAdr.delete();
        expDat.delete();
    endtask

    task automatic emit(input logic [31:0] w);
        loadImg[emitIdx] = w;
        emitIdx++;
    endtask

    task automatic expectStore(input logic [11:0] off, input logic [31:0] dat);
        expAdr.push_back({20'd0, off});
        expDat.push_back(dat);
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Error at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // reset and run the loaded program until halt
    task automatic runProgram();
        @(posedge clk);
        pulseReset <= 1'b1;
        repeat (4) @(posedge clk);
        pulseReset <= 1'b0;
        do begin
            @(negedge clk);
        end while (!halted);
    endtask

    task automatic compareStores(input string test);
        int n;
        checks++;
        assert (storeAdr.size() == expAdr.size()) else begin
            errors++;
            $display("%s test: %0d stores seen but %0d expected", test,
                     storeAdr.size(), expAdr.size());
        end
        n = (storeAdr.size() < expAdr.size()) ? storeAdr.size() : expAdr.size();
        for (int i = 0; i < n; i++) begin
            checkValue({test, " wbAdr"}, storeAdr[i], expAdr[i]);
            checkValue({test, " wbDatO"}, storeDat[i], expDat[i]);
        end
    endtask

    task automatic arithStep(input logic [31:0] w, input logic [11:0] off,
                             input logic [31:0] exp);
        emit(w);
        emit(encS(off, 5'd3));
        expectStore(off, exp);
    endtask

    task automatic arithTest();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] w;
        logic [11:0] imm [5];
        clearImage();
        drawBits(32, a);
        drawBits(32, b);
        for (int i = 0; i < 5; i++) begin
            drawBits(12, w);
            imm[i] = w[11:0];
        end
        loadImg[256] = a;
        loadImg[257] = b;
        emit(encI(12'h400, 5'd0, 3'b010, 5'd1, opLoad));
        emit(encI(12'h404, 5'd0, 3'b010, 5'd2, opLoad));
        arithStep(encR(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 12'h600, a + b);
        arithStep(encR(7'h20, 5'd2, 5'd1, 3'b000, 5'd3), 12'h604, a - b);
        arithStep(encR(7'h00, 5'd2, 5'd1, 3'b111, 5'd3), 12'h608, a & b);
        arithStep(encR(7'h00, 5'd2, 5'd1, 3'b110, 5'd3), 12'h60c, a | b);
        arithStep(encR(7'h00, 5'd2, 5'd1, 3'b100, 5'd3), 12'h610, a ^ b);
        arithStep(encR(7'h00, 5'd2, 5'd1, 3'b010, 5'd3), 12'h614,
                  {31'd0, $signed(a) < $signed(b)});
        arithStep(encI(imm[0], 5'd1, 3'b000, 5'd3, opArithImm), 12'h618, a + sext(imm[0]));
        arithStep(encI(imm[1], 5'd1, 3'b111, 5'd3, opArithImm), 12'h61c, a & sext(imm[1]));
        arithStep(encI(imm[2], 5'd1, 3'b110, 5'd3, opArithImm), 12'h620, a | sext(imm[2]));
        arithStep(encI(imm[3], 5'd1, 3'b100, 5'd3, opArithImm), 12'h624, a ^ sext(imm[3]));
        arithStep(encI(imm[4], 5'd1, 3'b010, 5'd3, opArithImm), 12'h628,
                  {31'd0, $signed(a) < $signed(sext(imm[4]))});
        emit(encI(12'd0, 5'd0, 3'd0, 5'd0, opSystem));
        runProgram();
        compareStores("arith");
    endtask

    task automatic loadStoreTest();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        clearImage();
        drawBits(32, a);
        drawBits(32, b);
        drawBits(32, c);
        loadImg[256] = a;
        loadImg[361] = b;
        loadImg[290] = c;
        emit(encI(12'h400, 5'd0, 3'b010, 5'd1, opLoad));
        emit(encI(12'h5a4, 5'd0, 3'b010, 5'd2, opLoad));
        emit(encI(12'h488, 5'd0, 3'b010, 5'd3, opLoad));
        emit(encR(7'h00, 5'd2, 5'd1, 3'b000, 5'd4));
        emit(encR(7'h00, 5'd3, 5'd4, 3'b100, 5'd4));
        emit(encS(12'h600, 5'd4));
        emit(encS(12'h7f0, 5'd1));
        emit(encI(12'h7f0, 5'd0, 3'b010, 5'd5, opLoad));
        emit(encS(12'h604, 5'd5));
        // writes to x0 must be lost
        emit(encI(12'h400, 5'd0, 3'b010, 5'd0, opLoad));
        emit(encS(12'h608, 5'd0));
        emit(encI(12'd123, 5'd0, 3'b000, 5'd0, opArithImm));
        emit(encS(12'h60c, 5'd0));
        emit(encI(12'd0, 5'd0, 3'd0, 5'd0, opSystem));
        expectStore(12'h600, (a + b) ^ c);
        expectStore(12'h7f0, a);
        expectStore(12'h604, a);
        expectStore(12'h608, 32'd0);
        expectStore(12'h60c, 32'd0);
        runProgram();
        compareStores("load/store");
    endtask

    // a taken branch skips one wrong-path store
    task automatic branchCase(input int k, input logic [2:0] f3, input logic [4:0] rs1,
                              input logic [4:0] rs2, input logic taken);
        logic [11:0] off;
        off = 12'h610 + 12'(4 * k);
        emit(encB(13'd8, rs2, rs1, f3));
        if (taken) begin
            emit(encS(12'h700, 5'd9));
            emit(encS(off, 5'd9));
        end else begin
            emit(encS(off, 5'd9));
        end
        expectStore(off, 32'h5a);
    endtask

    task automatic branchTest();
        clearImage();
        emit(encI(12'hffb, 5'd0, 3'b000, 5'd1, opArithImm));
        emit(encI(12'd7, 5'd0, 3'b000, 5'd2, opArithImm));
        emit(encI(12'hffb, 5'd0, 3'b000, 5'd3, opArithImm));
        emit(encI(12'h05a, 5'd0, 3'b000, 5'd9, opArithImm));
        branchCase(0, 3'b000, 5'd1, 5'd3, 1'b1);
        branchCase(1, 3'b000, 5'd1, 5'd2, 1'b0);
        branchCase(2, 3'b001, 5'd1, 5'd2, 1'b1);
        branchCase(3, 3'b001, 5'd1, 5'd3, 1'b0);
        // -5 < 7 only when signed
        branchCase(4, 3'b100, 5'd1, 5'd2, 1'b1);
        branchCase(5, 3'b100, 5'd2, 5'd1, 1'b0);
        branchCase(6, 3'b101, 5'd2, 5'd1, 1'b1);
        branchCase(7, 3'b101, 5'd1, 5'd2, 1'b0);
        branchCase(8, 3'b101, 5'd1, 5'd3, 1'b1);
        emit(encI(12'd0, 5'd0, 3'd0, 5'd0, opSystem));
        runProgram();
        compareStores("branch");
    endtask

    task automatic jumpTest();
        clearImage();
        emit(encI(12'h077, 5'd0, 3'b000, 5'd9, opArithImm));
        // jal at 4 lands at 16
        emit(encJ(21'd12, 5'd1));
        emit(encS(12'h700, 5'd9));
        emit(encS(12'h700, 5'd9));
        emit(encS(12'h620, 5'd1));
        emit(encI(12'd40, 5'd0, 3'b000, 5'd5, opArithImm));
        // jalr at 24 lands at 44
        emit(encI(12'd4, 5'd5, 3'b000, 5'd2, opJalr));
        for (int i = 0; i < 4; i++) begin
            emit(encS(12'h700, 5'd9));
        end
        emit(encS(12'h624, 5'd2));
        emit(encS(12'h628, 5'd9));
        emit(encI(12'd0, 5'd0, 3'd0, 5'd0, opSystem));
        expectStore(12'h620, 32'd4 + 32'd4);
        expectStore(12'h624, 32'd24 + 32'd4);
        expectStore(12'h628, 32'h77);
        runProgram();
        compareStores("jump");
    endtask

    task automatic ecallTest();
        clearImage();
        emit(encI(12'd1, 5'd0, 3'b000, 5'd1, opArithImm));
        emit(encI(12'd0, 5'd0, 3'd0, 5'd0, opSystem));
        emit(encS(12'h700, 5'd1));
        runProgram();
        // no bus traffic while halted
        for (int i = 0; i < 50; i++) begin
            @(negedge clk);
            checkValue("wbCyc", {31'd0, wbCyc}, 32'd0);
            checkValue("halted", {31'd0, halted}, 32'd1);
        end
        compareStores("ecall");
    endtask

    initial begin
        #(limitCycles * 4);
        $display("Timeout: the watchdog expired before the tests finished");
        $display("Regression failed");
        $finish;
    end

    initial begin
        pulseReset <= 1'b0;
        testLfsr = 32'h9dcb4610;
        checks   = 0;
        errors   = 0;
        @(negedge clk);
        while (genReset) begin
            @(negedge clk);
        end
        arithTest();
        loadStoreTest();
        branchTest();
        jumpTest();
        ecallTest();
        $display("checks %0d, errors %0d, bus checks %0d, bus errors %0d",
                 checks, errors, busChecks, busErrors);
        if (errors == 0 && busErrors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: tb/clockGen.sv
`timescale 1ns/100ps

module clockGen (
    output logic clk,
    output logic reset
);
    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        reset <= 1'b1;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// File: src/rvMulti.sv
`timescale 1ns/100ps

module rvMulti (
    input  logic                   clk,
    input  logic                   reset,
    output logic                   wbCyc,
    output logic                   wbStb,
    output logic                   wbWe,
    output logic [rvPkg::xlen-1:0] wbAdr,
    output logic [rvPkg::xlen-1:0] wbDatO,
    output logic [3:0]             wbSel,
    input  logic [rvPkg::xlen-1:0] wbDatI,
    input  logic                   wbAck,
    output logic                   halted
);
    import rvPkg::*;

    phaseT           phase;
    ctrlT            ctrl;
    busReqT          busReq;
    logic [6:0]      opcode;
    logic            branchTaken;
    logic [xlen-1:0] memAddr;
    logic [xlen-1:0] memWdata;
    logic [xlen-1:0] memRdata;
    logic            memDone;

    stateSequencer stateSequencerInst (
        .clk         (clk),
        .reset       (reset),
        .opcode      (opcode),
        .branchTaken (branchTaken),
        .memDone     (memDone),
        .phase       (phase)
    );

    microController microControllerInst (
        .phase       (phase),
        .opcode      (opcode),
        .branchTaken (branchTaken),
        .ctrl        (ctrl),
        .busReq      (busReq)
    );

    datapath datapathInst (
        .clk         (clk),
        .reset       (reset),
        .ctrl        (ctrl),
        .memRdata    (memRdata),
        .memDone     (memDone),
        .opcode      (opcode),
        .branchTaken (branchTaken),
        .memAddr     (memAddr),
        .memWdata    (memWdata)
    );

    // strobe and direction from control, address and data from the datapath
    wbMaster wbMasterInst (
        .clk    (clk),
        .reset  (reset),
        .busReq (busReq),
        .addr   (memAddr),
        .wdata  (memWdata),
        .wbCyc  (wbCyc),
        .wbStb  (wbStb),
        .wbWe   (wbWe),
        .wbAdr  (wbAdr),
        .wbDatO (wbDatO),
        .wbSel  (wbSel),
        .wbDatI (wbDatI),
        .wbAck  (wbAck),
        .rdata  (memRdata),
        .done   (memDone)
    );

    assign halted = (phase == phHalt);

endmodule

// File: src/wbMaster.sv
`timescale 1ns/100ps

module wbMaster (
    input  logic                   clk,
    input  logic                   reset,
    input  rvPkg::busReqT          busReq,
    input  logic [rvPkg::xlen-1:0] addr,
    input  logic [rvPkg::xlen-1:0] wdata,
    output logic                   wbCyc,
    output logic                   wbStb,
    output logic                   wbWe,
    output logic [rvPkg::xlen-1:0] wbAdr,
    output logic [rvPkg::xlen-1:0] wbDatO,
    output logic [3:0]             wbSel,
    input  logic [rvPkg::xlen-1:0] wbDatI,
    input  logic                   wbAck,
    output logic [rvPkg::xlen-1:0] rdata,
    output logic                   done
);
    import rvPkg::*;

    logic request;
    logic start;

    assign request = busReq.memRead || busReq.memWrite;
    // cyc is low in the cycle after ack, so a new cycle waits one clock
    assign start = request && !wbCyc;

    always_ff @(posedge clk) begin
        if (reset) begin
            wbCyc <= 1'b0;
            wbStb <= 1'b0;
        end else if (start) begin
            wbCyc <= 1'b1;
            wbStb <= 1'b1;
        end else if (wbCyc && wbAck) begin
            wbCyc <= 1'b0;
            wbStb <= 1'b0;
        end
    end

    // held until ack
    always_ff @(posedge clk) begin
        if (start) begin
            wbAdr  <= addr;
            wbDatO <= wdata;
            // fetches are always reads
            wbWe   <= busReq.memWrite && busReq.iOrD;
        end
    end

    assign wbSel = 4'hf;
    assign done  = wbCyc && wbAck;
    assign rdata = wbDatI;

endmodule

// File: src/datapath.sv
`timescale 1ns/100ps

module datapath (
    input  logic                   clk,
    input  logic                   reset,
    input  rvPkg::ctrlT            ctrl,
    input  logic [rvPkg::xlen-1:0] memRdata,
    input  logic                   memDone,
    output logic [6:0]             opcode,
    output logic                   branchTaken,
    output logic [rvPkg::xlen-1:0] memAddr,
    output logic [rvPkg::xlen-1:0] memWdata
);
    import rvPkg::*;

    logic [xlen-1:0] pc;
    logic [xlen-1:0] oldPc;
    instrT           ir;
    logic [xlen-1:0] mdr;
    logic [xlen-1:0] regA;
    logic [xlen-1:0] regB;
    logic [xlen-1:0] aluOut;
    logic [xlen-1:0] regFile [32];

    logic [xlen-1:0] imm;
    logic [xlen-1:0] opA;
    logic [xlen-1:0] opB;
    logic [xlen-1:0] aluResult;
    logic [xlen-1:0] wbData;
    logic [xlen-1:0] pcIn;
    logic            isSub;

    assign opcode = ir.rT.opcode;

    // immediate by format
    always_comb begin
        case (opcode)
            opStore:  imm = {{20{ir.sT.immHi[6]}}, ir.sT.immHi, ir.sT.immLo};
            opBranch: imm = {{19{ir.bT.imm12}}, ir.bT.imm12, ir.bT.imm11,
                             ir.bT.immHi, ir.bT.immLo, 1'b0};
            opJal:    imm = {{11{ir.jT.imm20}}, ir.jT.imm20, ir.jT.imm19to12,
                             ir.jT.imm11, ir.jT.imm10to1, 1'b0};
            default:  imm = {{20{ir.iT.imm[11]}}, ir.iT.imm};
        endcase
    end

    assign opA = (ctrl.srcA == srcA) ? regA : oldPc;

    always_comb begin
        case (ctrl.srcB)
            srcFour: opB = 32'd4;
            srcImm:  opB = imm;
            default: opB = regB;
        endcase
    end

    // funct7 bit 5 is an immediate bit in the I form
    assign isSub = ir.rT.funct7[5] && (opcode == opArith);

    always_comb begin
        case (ctrl.aluOp)
            aluBranch: aluResult = opA - opB;
            aluFunct: begin
                case (ir.rT.funct3)
                    3'b000:  aluResult = isSub ? opA - opB : opA + opB;
                    3'b010:  aluResult = {31'd0, $signed(opA) < $signed(opB)};
                    3'b100:  aluResult = opA ^ opB;
                    3'b110:  aluResult = opA | opB;
                    3'b111:  aluResult = opA & opB;
                    default: aluResult = opA + opB;
                endcase
            end
            default: aluResult = opA + opB;
        endcase
    end

    always_comb begin
        case (ir.bT.funct3)
            3'b000:  branchTaken = (regA == regB);
            3'b001:  branchTaken = (regA != regB);
            3'b100:  branchTaken = $signed(regA) < $signed(regB);
            3'b101:  branchTaken = $signed(regA) >= $signed(regB);
            default: branchTaken = 1'b0;
        endcase
    end

    always_comb begin
        case (ctrl.wbSel)
            wbMem:   wbData = mdr;
            wbLink:  wbData = aluResult;
            default: wbData = aluOut;
        endcase
    end

    // not-taken and jump targets come from ALUOut, bit 0 cleared for jalr
    assign pcIn = (ctrl.pcWriteNotCond || ctrl.wbSel == wbLink) ?
                  {aluOut[xlen-1:1], 1'b0} : aluResult;

    assign memAddr  = ctrl.iOrD ? aluOut : pc;
    assign memWdata = regB;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (ctrl.pcWrite || ctrl.pcWriteNotCond) begin
            pc <= pcIn;
        end
    end

    always_ff @(posedge clk) begin
        if (memDone && ctrl.irWrite) begin
            ir    <= memRdata;
            oldPc <= pc;
        end
        if (memDone && ctrl.memRead && ctrl.iOrD) begin
            mdr <= memRdata;
        end
        // operands frozen once halting
        if (!ctrl.isEcall) begin
            regA <= (ir.rT.rs1 == 5'd0) ? '0 : regFile[ir.rT.rs1];
            regB <= (ir.rT.rs2 == 5'd0) ? '0 : regFile[ir.rT.rs2];
            // address held for the whole data phase
            if (!ctrl.iOrD) begin
                aluOut <= aluResult;
            end
        end
        if (ctrl.regWrite && ir.rT.rd != 5'd0) begin
            regFile[ir.rT.rd] <= wbData;
        end
    end

endmodule

// File: src/microController.sv
`timescale 1ns/100ps

module microController (
    input  rvPkg::phaseT  phase,
    input  logic [6:0]    opcode,
    input  logic          branchTaken,
    output rvPkg::ctrlT   ctrl,
    output rvPkg::busReqT busReq
);
    import rvPkg::*;

    always_comb begin
        ctrl.pcWrite        = 1'b0;
        ctrl.pcWriteNotCond = 1'b0;
        ctrl.iOrD           = 1'b0;
        ctrl.memRead        = 1'b0;
        ctrl.memWrite       = 1'b0;
        ctrl.irWrite        = 1'b0;
        ctrl.regWrite       = 1'b0;
        ctrl.isEcall        = 1'b0;
        ctrl.aluOp          = aluAdd;
        ctrl.srcA           = srcPc;
        ctrl.srcB           = srcB;
        ctrl.wbSel          = wbAlu;

        case (phase)
            // fetch from PC into IR
            phIf: begin
                ctrl.memRead = 1'b1;
                ctrl.irWrite = 1'b1;
            end
            // oldPc+4 into ALUOut for a branch not taken
            phId: begin
                ctrl.isEcall = (opcode == opSystem);
                ctrl.srcB    = srcFour;
            end
            phEx1: begin
                case (opcode)
                    opArith: begin
                        ctrl.srcA  = srcA;
                        ctrl.aluOp = aluFunct;
                    end
                    opArithImm: begin
                        ctrl.srcA  = srcA;
                        ctrl.srcB  = srcImm;
                        ctrl.aluOp = aluFunct;
                    end
                    // effective address and the jalr target
                    opLoad, opStore, opJalr: begin
                        ctrl.srcA = srcA;
                        ctrl.srcB = srcImm;
                    end
                    opBranch: begin
                        ctrl.srcA           = srcA;
                        ctrl.aluOp          = aluBranch;
                        ctrl.pcWriteNotCond = !branchTaken;
                    end
                    opJal: begin
                        ctrl.srcB = srcImm;
                    end
                    default: begin
                    end
                endcase
            end
            // taken branch target
            phEx2: begin
                ctrl.pcWrite = 1'b1;
                ctrl.srcB    = srcImm;
            end
            phMem: begin
                ctrl.iOrD = 1'b1;
                if (opcode == opLoad) begin
                    ctrl.memRead = 1'b1;
                end else begin
                    ctrl.memWrite = 1'b1;
                    ctrl.pcWrite  = 1'b1;
                    ctrl.srcB     = srcFour;
                end
            end
            phWb: begin
                ctrl.pcWrite  = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.srcB     = srcFour;
                if (opcode == opLoad) begin
                    ctrl.wbSel = wbMem;
                end else if (opcode == opJal || opcode == opJalr) begin
                    // rd gets oldPc+4 live while PC gets the latched target
                    ctrl.wbSel = wbLink;
                end
            end
            phHalt: begin
                ctrl.isEcall = 1'b1;
            end
            default: begin
            end
        endcase
    end

    assign busReq.memRead  = ctrl.memRead;
    assign busReq.memWrite = ctrl.memWrite;
    assign busReq.iOrD     = ctrl.iOrD;

endmodule

// File: src/stateSequencer.sv
`timescale 1ns/100ps

module stateSequencer (
    input  logic        clk,
    input  logic        reset,
    input  logic [6:0]  opcode,
    input  logic        branchTaken,
    input  logic        memDone,
    output rvPkg::phaseT phase
);
    import rvPkg::*;

    phaseT nextPhase;

    always_comb begin
        nextPhase = phase;
        case (phase)
            // bus phases hold until the slave acks
            phIf: begin
                if (memDone) begin
                    nextPhase = phId;
                end
            end
            phId: begin
                if (opcode == opSystem) begin
                    nextPhase = phHalt;
                end else begin
                    nextPhase = phEx1;
                end
            end
            phEx1: begin
                case (opcode)
                    opArith, opArithImm, opJal, opJalr: nextPhase = phWb;
                    opLoad, opStore: nextPhase = phMem;
                    opBranch: nextPhase = branchTaken ? phEx2 : phIf;
                    default: nextPhase = phIf;
                endcase
            end
            phEx2: nextPhase = phIf;
            phMem: begin
                if (memDone) begin
                    // stores finish here, loads still write rd
                    nextPhase = (opcode == opLoad) ? phWb : phIf;
                end
            end
            phWb: nextPhase = phIf;
            // only reset leaves halt
            phHalt: nextPhase = phHalt;
            default: nextPhase = phIf;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= phIf;
        end else begin
            phase <= nextPhase;
        end
    end

endmodule

// File: src/rvPkg.sv
package rvPkg;

    localparam int xlen = 32;

    // rv32i major opcodes
    localparam logic [6:0] opArith    = 7'b0110011;
    localparam logic [6:0] opArithImm = 7'b0010011;
    localparam logic [6:0] opLoad     = 7'b0000011;
    localparam logic [6:0] opStore    = 7'b0100011;
    localparam logic [6:0] opBranch   = 7'b1100011;
    localparam logic [6:0] opJal      = 7'b1101111;
    localparam logic [6:0] opJalr     = 7'b1100111;
    localparam logic [6:0] opSystem   = 7'b1110011;

    typedef enum logic [1:0] {aluAdd, aluBranch, aluFunct} aluOpT;
    typedef enum logic {srcPc, srcA} srcAT;
    typedef enum logic [1:0] {srcB, srcFour, srcImm} srcBT;
    typedef enum logic [1:0] {wbAlu, wbMem, wbLink} wbSelT;

    typedef enum logic [2:0] {phIf, phId, phEx1, phEx2, phMem, phWb, phHalt} phaseT;

    typedef struct packed {
        logic  pcWrite;
        logic  pcWriteNotCond;
        logic  iOrD;
        logic  memRead;
        logic  memWrite;
        logic  irWrite;
        logic  regWrite;
        logic  isEcall;
        aluOpT aluOp;
        srcAT  srcA;
        srcBT  srcB;
        wbSelT wbSel;
    } ctrlT;

    typedef struct packed {
        logic memRead;
        logic memWrite;
        logic iOrD;
    } busReqT;

    // instruction formats, one view each
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rTypeT;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iTypeT;

    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } sTypeT;

    typedef struct packed {
        logic       imm12;
        logic [5:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] immLo;
        logic       imm11;
        logic [6:0] opcode;
    } bTypeT;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10to1;
        logic       imm11;
        logic [7:0] imm19to12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } jTypeT;

    typedef union packed {
        rTypeT rT;
        iTypeT iT;
        sTypeT sT;
        bTypeT bT;
        jTypeT jT;
    } instrT;

endpackage
